// ==== lsu_pkg.sv ====
// Load/store unit shared types
`default_nettype none

package lsu_pkg;

   // ********************************************************
   // Basic data types
   // ********************************************************

   typedef logic [31:0]        data_t;    // One data word
   typedef logic [31:0]        addr_t;    // Byte address
   typedef logic signed [11:0] offset_t;  // Immediate offset from the instruction
   typedef logic [3:0]         byteen_t;  // One bit per byte lane

   // ********************************************************
   // Access size and completion status
   // ********************************************************

   typedef enum logic [1:0] {
      SIZE_BYTE = 2'b00,
      SIZE_HALF = 2'b01,
      SIZE_WORD = 2'b10
   } lsu_size_e;

   // Misaligned wins over access fault when both apply
   typedef enum logic [1:0] {
      ERR_NONE     = 2'b00,
      ERR_MISALIGN = 2'b01,
      ERR_ACCESS   = 2'b10
   } lsu_err_e;

   // ********************************************************
   // Memory map
   // ********************************************************

   // Start of the DCCM window
   localparam addr_t DCCM_BASE = 32'hF004_0000;

endpackage

`default_nettype wire

// ==== lsu_dccm.sv ====
// DCCM single-port memory
`default_nettype none

module lsu_dccm #(
   parameter int DCCM_WORDS = 1024
) (
   input  logic             clk,
   input  logic             rd_en,
   input  lsu_pkg::addr_t   rd_addr,
   input  logic             wr_en,
   input  lsu_pkg::addr_t   wr_addr,
   input  lsu_pkg::byteen_t wr_byteen,
   input  lsu_pkg::data_t   wr_data,
   output lsu_pkg::data_t   rd_data
);
   import lsu_pkg::*;

   localparam int IDX_W = $clog2(DCCM_WORDS);

   data_t mem [DCCM_WORDS];
   addr_t rd_off;
   addr_t wr_off;

   // Offsets within the window
   assign rd_off = rd_addr - DCCM_BASE;
   assign wr_off = wr_addr - DCCM_BASE;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < 4; b++) begin
            if (wr_byteen[b]) begin
               mem[wr_off[IDX_W+1:2]][8*b +: 8] <= wr_data[8*b +: 8];
            end
         end
      end
      if (rd_en) begin
         rd_data <= mem[rd_off[IDX_W+1:2]];  // Data ready in dc2
      end
   end

   // Loads own the port, the buffer drains only in free cycles
   a_single_port: assert property (@(posedge clk) !(rd_en && wr_en));

endmodule

`default_nettype wire

// ==== lsu_addr_check.sv ====
// Address generation and checks
`default_nettype none

module lsu_addr_check #(
   parameter int DCCM_WORDS = 1024
) (
   input  logic               clk,
   input  logic               rst_n,
   input  lsu_pkg::data_t     rs1,
   input  lsu_pkg::offset_t   offset,
   input  lsu_pkg::data_t     store_data,
   input  lsu_pkg::lsu_size_e req_size,
   input  logic               accept,
   output lsu_pkg::lsu_err_e  err_dc1,
   output lsu_pkg::addr_t     addr_dc1,
   output lsu_pkg::addr_t     addr_dc2,
   output lsu_pkg::byteen_t   byteen_dc2,
   output lsu_pkg::data_t     wdata_dc2
);
   import lsu_pkg::*;

   localparam addr_t WIN_BYTES = addr_t'(4 * DCCM_WORDS);

   data_t     rs1_dc1;
   data_t     sdata_dc1;
   offset_t   offset_dc1;
   lsu_size_e size_dc1;
   addr_t     win_off;
   logic      misaligned;
   logic      in_window;
   byteen_t   byteen_dc1;

   // Operands captured on the accepting edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rs1_dc1    <= '0;
         sdata_dc1  <= '0;
         offset_dc1 <= '0;
         size_dc1   <= SIZE_BYTE;
      end else if (accept) begin
         rs1_dc1    <= rs1;
         sdata_dc1  <= store_data;
         offset_dc1 <= offset;
         size_dc1   <= req_size;
      end
   end

   assign addr_dc1 = rs1_dc1 + {{20{offset_dc1[11]}}, offset_dc1};

   // Below the base wraps to a large offset
   assign win_off   = addr_dc1 - DCCM_BASE;
   assign in_window = (win_off < WIN_BYTES);

   assign misaligned = ((size_dc1 == SIZE_HALF) && addr_dc1[0]) ||
                       ((size_dc1 == SIZE_WORD) && (addr_dc1[1:0] != 2'b00));

   assign err_dc1 = misaligned ? ERR_MISALIGN :
                    !in_window ? ERR_ACCESS   : ERR_NONE;

   always_comb begin
      case (size_dc1)
         SIZE_BYTE: byteen_dc1 = 4'b0001 << addr_dc1[1:0];
         SIZE_HALF: byteen_dc1 = 4'b0011 << addr_dc1[1:0];
         default:   byteen_dc1 = 4'b1111;
      endcase
   end

   // Store data moved to its byte lanes for the buffer
   always_ff @(posedge clk) begin
      addr_dc2   <= addr_dc1;
      byteen_dc2 <= byteen_dc1;
      wdata_dc2  <= sdata_dc1 << {addr_dc1[1:0], 3'b000};
   end

endmodule

`default_nettype wire

// ==== lsu_stbuf.sv ====
// Store buffer with load forwarding
`default_nettype none

module lsu_stbuf #(
   parameter int STBUF_DEPTH = 4
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               push,
   input  logic                               drain,
   input  lsu_pkg::addr_t                     push_addr,
   input  lsu_pkg::byteen_t                   push_byteen,
   input  lsu_pkg::data_t                     push_data,
   input  lsu_pkg::addr_t                     ld_addr,
   output logic [$clog2(STBUF_DEPTH + 1)-1:0] count,
   output lsu_pkg::addr_t                     wr_addr,
   output lsu_pkg::byteen_t                   wr_byteen,
   output lsu_pkg::data_t                     wr_data,
   output lsu_pkg::byteen_t                   fwd_byteen,
   output lsu_pkg::data_t                     fwd_data
);
   import lsu_pkg::*;

   localparam int PTR_W = $clog2(STBUF_DEPTH);
   localparam int CNT_W = $clog2(STBUF_DEPTH + 1);

   logic [29:0]      ent_addr [STBUF_DEPTH];  // Word address only
   byteen_t          ent_be   [STBUF_DEPTH];
   data_t            ent_data [STBUF_DEPTH];  // Already in byte lanes
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(STBUF_DEPTH - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   // ********************************************************
   // Pointers and occupancy
   // ********************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (drain) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count <= count + CNT_W'(push) - CNT_W'(drain);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         ent_addr[wr_ptr] <= push_addr[31:2];
         ent_be[wr_ptr]   <= push_byteen;
         ent_data[wr_ptr] <= push_data;
      end
   end

   // Oldest entry goes to the DCCM
   assign wr_addr   = {ent_addr[rd_ptr], 2'b00};
   assign wr_byteen = ent_be[rd_ptr];
   assign wr_data   = ent_data[rd_ptr];

   // ********************************************************
   // Forwarding
   // ********************************************************

   // Walk oldest to youngest so younger matches overwrite older bytes
   always_comb begin
      int idx;
      fwd_byteen = '0;
      fwd_data   = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         idx = int'(rd_ptr) + i;
         if (idx >= STBUF_DEPTH) begin
            idx = idx - STBUF_DEPTH;
         end
         if ((i < int'(count)) && (ent_addr[idx] == ld_addr[31:2])) begin
            for (int b = 0; b < 4; b++) begin
               if (ent_be[idx][b]) begin
                  fwd_byteen[b]      = 1'b1;
                  fwd_data[8*b +: 8] = ent_data[idx][8*b +: 8];
               end
            end
         end
      end
   end

   a_no_drain_empty: assert property (@(posedge clk) disable iff (!rst_n)
      drain |-> (count != '0));

endmodule

`default_nettype wire

// ==== lsu_load_align.sv ====
// Load data merge and alignment
`default_nettype none

module lsu_load_align (
   input  logic               clk,
   input  logic               rst_n,
   input  lsu_pkg::data_t     rd_data,
   input  lsu_pkg::byteen_t   fwd_byteen,
   input  lsu_pkg::data_t     fwd_data,
   input  lsu_pkg::addr_t     addr_dc2,
   input  lsu_pkg::lsu_size_e size_dc2,
   input  logic               unsigned_dc2,
   input  lsu_pkg::lsu_err_e  err_dc2,
   input  logic               dc2_load,
   output lsu_pkg::data_t     result_data,
   output lsu_pkg::lsu_err_e  result_err,
   output lsu_pkg::addr_t     result_addr
);
   import lsu_pkg::*;

   data_t merged;
   data_t shifted;
   data_t ext;

   // Buffer bytes take priority over memory
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged[8*b +: 8] = fwd_byteen[b] ? fwd_data[8*b +: 8] : rd_data[8*b +: 8];
      end
   end

   assign shifted = merged >> {addr_dc2[1:0], 3'b000};  // Addressed byte to lane 0

   always_comb begin
      case (size_dc2)
         SIZE_BYTE: ext = unsigned_dc2 ? {24'h0, shifted[7:0]}
                                       : {{24{shifted[7]}}, shifted[7:0]};
         SIZE_HALF: ext = unsigned_dc2 ? {16'h0, shifted[15:0]}
                                       : {{16{shifted[15]}}, shifted[15:0]};
         default:   ext = shifted;
      endcase
   end

   // ********************************************************
   // Completion register
   // ********************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         result_data <= '0;
         result_err  <= ERR_NONE;
         result_addr <= '0;
      end else begin
         result_data <= (dc2_load && (err_dc2 == ERR_NONE)) ? ext : '0;  // Stores give zero
         result_err  <= err_dc2;
         result_addr <= addr_dc2;
      end
   end

endmodule

`default_nettype wire

// ==== lsu_pipe_ctl.sv ====
// Load/store pipeline control
`default_nettype none

module lsu_pipe_ctl #(
   parameter int STBUF_DEPTH = 4
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               req_valid,
   input  logic                               req_store,
   input  logic                               req_unsigned,
   input  lsu_pkg::lsu_size_e                 req_size,
   input  lsu_pkg::lsu_err_e                  err_dc1,
   input  logic [$clog2(STBUF_DEPTH + 1)-1:0] stbuf_count,
   output logic                               stall,
   output logic                               dc1_load,
   output logic                               dc2_load,
   output logic                               push,
   output logic                               drain,
   output logic                               result_valid,
   output logic                               idle,
   output logic                               unsigned_dc2,
   output lsu_pkg::lsu_size_e                 size_dc2,
   output lsu_pkg::lsu_err_e                  err_dc2
);
   import lsu_pkg::*;

   localparam int CNT_W = $clog2(STBUF_DEPTH + 1);
   localparam int PW    = CNT_W + 1;

   logic      accept;
   logic      valid_dc1;
   logic      store_dc1;
   logic      unsigned_dc1;
   lsu_size_e size_dc1;
   logic      valid_dc2;
   logic      store_dc2;
   logic [PW-1:0] st_pending;  // Buffer entries plus stores still in the pipe

   // ********************************************************
   // Acceptance and stall
   // ********************************************************

   assign st_pending = PW'(stbuf_count) + PW'(valid_dc1 & store_dc1)
                     + PW'(valid_dc2 & store_dc2);

   // Hold off requests early enough that a push always finds room
   assign stall  = (st_pending >= PW'(STBUF_DEPTH - 1));
   assign accept = req_valid & ~stall;

   // ********************************************************
   // Stage registers
   // ********************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_dc1    <= 1'b0;
         store_dc1    <= 1'b0;
         unsigned_dc1 <= 1'b0;
         size_dc1     <= SIZE_BYTE;
         valid_dc2    <= 1'b0;
         store_dc2    <= 1'b0;
         unsigned_dc2 <= 1'b0;
         size_dc2     <= SIZE_BYTE;
         err_dc2      <= ERR_NONE;
         result_valid <= 1'b0;
      end else begin
         valid_dc1    <= accept;
         store_dc1    <= req_store;
         unsigned_dc1 <= req_unsigned;
         size_dc1     <= req_size;
         valid_dc2    <= valid_dc1;
         store_dc2    <= store_dc1;
         unsigned_dc2 <= unsigned_dc1;
         size_dc2     <= size_dc1;
         err_dc2      <= err_dc1;      // Error found in dc1 travels with the request
         result_valid <= valid_dc2;    // Completion two edges after acceptance
      end
   end

   assign dc1_load = valid_dc1 & ~store_dc1;  // DCCM read port taken this cycle
   assign dc2_load = valid_dc2 & ~store_dc2;

   // Only clean stores enter the buffer
   assign push  = valid_dc2 & store_dc2 & (err_dc2 == ERR_NONE);
   assign drain = (stbuf_count != '0) & ~dc1_load;
   assign idle  = ~valid_dc1 & ~valid_dc2 & (stbuf_count == '0);

   a_push_has_room: assert property (@(posedge clk) disable iff (!rst_n)
      push |-> (stbuf_count != CNT_W'(STBUF_DEPTH)));

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
// Load/store unit top level
`default_nettype none

module lsu_top #(
   parameter int DCCM_WORDS  = 1024,
   parameter int STBUF_DEPTH = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   // Request side
   input  logic                req_valid,
   input  logic                req_store,
   input  logic                req_unsigned,
   input  lsu_pkg::lsu_size_e  req_size,
   input  lsu_pkg::data_t      rs1,
   input  lsu_pkg::data_t      store_data,
   input  lsu_pkg::offset_t    offset,
   output logic                stall,
   // Completion side
   output logic                result_valid,
   output logic                idle,
   output lsu_pkg::data_t      result_data,
   output lsu_pkg::lsu_err_e   result_err,
   output lsu_pkg::addr_t      result_addr
);
   import lsu_pkg::*;

   localparam int CNT_W = $clog2(STBUF_DEPTH + 1);

   lsu_err_e         err_dc1;
   lsu_err_e         err_dc2;
   lsu_size_e        size_dc2;
   logic             unsigned_dc2;
   logic             dc1_load;
   logic             dc2_load;
   addr_t            addr_dc1;
   addr_t            addr_dc2;
   byteen_t          byteen_dc2;
   data_t            wdata_dc2;
   logic             push;
   logic             drain;
   logic [CNT_W-1:0] stbuf_count;
   addr_t            wr_addr;   // Oldest buffer entry going to the DCCM
   byteen_t          wr_byteen;
   data_t            wr_data;
   byteen_t          fwd_byteen;
   data_t            fwd_data;
   data_t            rd_data;

   lsu_pipe_ctl #(.STBUF_DEPTH(STBUF_DEPTH)) u_pipe_ctl (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req_store    (req_store),
      .req_unsigned (req_unsigned),
      .req_size     (req_size),
      .err_dc1      (err_dc1),
      .stbuf_count  (stbuf_count),
      .stall        (stall),
      .dc1_load     (dc1_load),
      .dc2_load     (dc2_load),
      .push         (push),
      .drain        (drain),
      .result_valid (result_valid),
      .idle         (idle),
      .unsigned_dc2 (unsigned_dc2),
      .size_dc2     (size_dc2),
      .err_dc2      (err_dc2)
   );

   lsu_addr_check #(.DCCM_WORDS(DCCM_WORDS)) u_addr_check (
      .clk        (clk),
      .rst_n      (rst_n),
      .rs1        (rs1),
      .offset     (offset),
      .store_data (store_data),
      .req_size   (req_size),
      .accept     (req_valid & ~stall),
      .err_dc1    (err_dc1),
      .addr_dc1   (addr_dc1),
      .addr_dc2   (addr_dc2),
      .byteen_dc2 (byteen_dc2),
      .wdata_dc2  (wdata_dc2)
   );

   lsu_stbuf #(.STBUF_DEPTH(STBUF_DEPTH)) u_stbuf (
      .clk         (clk),
      .rst_n       (rst_n),
      .push        (push),
      .drain       (drain),
      .push_addr   (addr_dc2),
      .push_byteen (byteen_dc2),
      .push_data   (wdata_dc2),
      .ld_addr     (addr_dc2),
      .count       (stbuf_count),
      .wr_addr     (wr_addr),
      .wr_byteen   (wr_byteen),
      .wr_data     (wr_data),
      .fwd_byteen  (fwd_byteen),
      .fwd_data    (fwd_data)
   );

   lsu_dccm #(.DCCM_WORDS(DCCM_WORDS)) u_dccm (
      .clk       (clk),
      .rd_en     (dc1_load),
      .rd_addr   (addr_dc1),
      .wr_en     (drain),
      .wr_addr   (wr_addr),
      .wr_byteen (wr_byteen),
      .wr_data   (wr_data),
      .rd_data   (rd_data)
   );

   lsu_load_align u_load_align (
      .clk          (clk),
      .rst_n        (rst_n),
      .rd_data      (rd_data),
      .fwd_byteen   (fwd_byteen),
      .fwd_data     (fwd_data),
      .addr_dc2     (addr_dc2),
      .size_dc2     (size_dc2),
      .unsigned_dc2 (unsigned_dc2),
      .err_dc2      (err_dc2),
      .dc2_load     (dc2_load),
      .result_data  (result_data),
      .result_err   (result_err),
      .result_addr  (result_addr)
   );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// Testbench clock source
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS = 8
) (
   output logic clk
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
   end

   always #(PERIOD_NS / 2.0) clk = ~clk;  // 50 % duty cycle

endmodule

`default_nettype wire

// ==== tb_lsu.sv ====
// Load/store unit testbench
`default_nettype none

module tb_lsu;
   timeunit 1ns;
   timeprecision 1ps;
   import lsu_pkg::*;

   localparam int DCCM_WORDS  = 1024;
   localparam int STBUF_DEPTH = 4;
   localparam int WAIT_LIMIT  = 200;  // Cycles any single wait may take

   // One row of the stimulus table
   typedef struct packed {
      logic      st;
      lsu_size_e size;
      logic      uns;
      data_t     rs1;
      offset_t   off;
      data_t     sdata;
      lsu_err_e  err;
   } entry_t;

   logic      clk;
   logic      rst_n;
   logic      req_valid;
   logic      req_store;
   logic      req_unsigned;
   lsu_size_e req_size;
   data_t     rs1;
   data_t     store_data;
   offset_t   offset;
   logic      stall;
   logic      result_valid;
   logic      idle;
   data_t     result_data;
   lsu_err_e  result_err;
   addr_t     result_addr;

   entry_t     tbl [$];
   logic [7:0] ref_mem [4*DCCM_WORDS];  // Byte image of the DCCM
   data_t      exp_data [$];
   lsu_err_e   exp_err [$];
   addr_t      exp_addr [$];
   int         exp_cycle [$];
   data_t      got_data [$];
   lsu_err_e   got_err [$];
   addr_t      got_addr [$];
   int         got_cycle [$];

   int     cycle = 0;
   int     errors = 0;
   int     lat_errors = 0;
   int     checks = 0;
   int     tests = 0;
   int     test_base;
   integer seed;
   logic   saw_stall;
   logic   timed_out;

   tb_clk_gen #(.PERIOD_NS(8)) u_clk_gen (.clk(clk));

   lsu_top #(
      .DCCM_WORDS  (DCCM_WORDS),
      .STBUF_DEPTH (STBUF_DEPTH)
   ) uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req_store    (req_store),
      .req_unsigned (req_unsigned),
      .req_size     (req_size),
      .rs1          (rs1),
      .store_data   (store_data),
      .offset       (offset),
      .stall        (stall),
      .result_valid (result_valid),
      .idle         (idle),
      .result_data  (result_data),
      .result_err   (result_err),
      .result_addr  (result_addr)
   );

   always @(posedge clk) cycle <= cycle + 1;

   // Completions sampled mid-cycle where they are stable
   always @(negedge clk) begin
      if (rst_n && result_valid) begin
         got_data.push_back(result_data);
         got_err.push_back(result_err);
         got_addr.push_back(result_addr);
         got_cycle.push_back(cycle);
      end
   end

   // ************************************************************
   // Reference model
   // ************************************************************

   function automatic addr_t eff_addr(input data_t base, input offset_t off);
      return base + {{20{off[11]}}, off};
   endfunction

   function automatic data_t model_load(input addr_t a, input lsu_size_e sz, input logic uns);
      int    i;
      data_t v;
      i = int'(a - DCCM_BASE);
      case (sz)
         SIZE_BYTE: v = uns ? {24'h0, ref_mem[i]} : {{24{ref_mem[i][7]}}, ref_mem[i]};
         SIZE_HALF: v = uns ? {16'h0, ref_mem[i+1], ref_mem[i]}
                            : {{16{ref_mem[i+1][7]}}, ref_mem[i+1], ref_mem[i]};
         default:   v = {ref_mem[i+3], ref_mem[i+2], ref_mem[i+1], ref_mem[i]};
      endcase
      return v;
   endfunction

   task automatic model_store(input addr_t a, input lsu_size_e sz, input data_t d);
      int i;
      int n;
      i = int'(a - DCCM_BASE);
      n = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
      for (int k = 0; k < n; k++) begin
         ref_mem[i+k] = d[8*k +: 8];
      end
   endtask

   // ************************************************************
   // Compare tasks
   // ************************************************************

   task automatic check_data(input string name, input data_t got, input data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_err(input string name, input lsu_err_e got, input lsu_err_e exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_cycle(input string name, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         lat_errors++;
         $display("[ERROR] %0t %s got cycle %0d expected %0d", $time, name, got, exp);
      end
   endtask

   // ************************************************************
   // Stimulus
   // ************************************************************

   task automatic timeout_fail(input string what);
      errors++;
      timed_out = 1'b1;
      $display("Timeout at %0t: %s", $time, what);
   endtask

   task automatic add_req(input logic st, input lsu_size_e sz, input logic uns,
                          input data_t base, input offset_t off, input data_t sd,
                          input lsu_err_e err);
      entry_t e;
      e.st    = st;
      e.size  = sz;
      e.uns   = uns;
      e.rs1   = base;
      e.off   = off;
      e.sdata = sd;
      e.err   = err;
      tbl.push_back(e);
   endtask

   // Called right after a rising edge and returns right after the accepting edge
   task automatic send_req(input entry_t e);
      addr_t a;
      int    n;
      a = eff_addr(e.rs1, e.off);
      exp_addr.push_back(a);
      exp_err.push_back(e.err);
      if (e.st || e.err != ERR_NONE) begin
         exp_data.push_back('0);
      end else begin
         exp_data.push_back(model_load(a, e.size, e.uns));
      end
      if (e.st && e.err == ERR_NONE) begin
         model_store(a, e.size, e.sdata);
      end
      req_valid    <= 1'b1;
      req_store    <= e.st;
      req_size     <= e.size;
      req_unsigned <= e.uns;
      rs1          <= e.rs1;
      offset       <= e.off;
      store_data   <= e.sdata;
      n = 0;
      @(negedge clk);
      while (stall && n < WAIT_LIMIT) begin
         saw_stall = 1'b1;
         n++;
         @(negedge clk);
      end
      if (stall) begin
         timeout_fail("request held off by stall too long");
      end else begin
         exp_cycle.push_back(cycle + 3);  // Accepting edge is the next one
         @(posedge clk);
      end
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      while (got_data.size() < exp_data.size() && n < WAIT_LIMIT) begin
         n++;
         @(negedge clk);
      end
      if (got_data.size() < exp_data.size()) begin
         timeout_fail("completions missing");
      end else begin
         n = 0;
         while (idle !== 1'b1 && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
         end
         if (idle !== 1'b1) begin
            timeout_fail("unit never returned to idle");
         end else begin
            repeat (3) @(negedge clk);  // Room for a stray completion
         end
      end
   endtask

   task automatic run_table();
      @(posedge clk);
      foreach (tbl[i]) begin
         if (!timed_out) begin
            send_req(tbl[i]);
         end
      end
      req_valid <= 1'b0;
      tbl.delete();
      if (!timed_out) begin
         wait_done();
      end
      if (!timed_out) begin
         if (got_data.size() != exp_data.size()) begin
            errors++;
            $display("Completion count wrong at %0t: %0d seen for %0d requests",
                     $time, got_data.size(), exp_data.size());
         end
         while (exp_data.size() > 0 && got_data.size() > 0) begin
            check_data("result_data", got_data.pop_front(), exp_data.pop_front());
            check_err("result_err", got_err.pop_front(), exp_err.pop_front());
            check_addr("result_addr", got_addr.pop_front(), exp_addr.pop_front());
            check_cycle("result_valid", got_cycle.pop_front(), exp_cycle.pop_front());
         end
      end
      exp_data.delete();
      exp_err.delete();
      exp_addr.delete();
      exp_cycle.delete();
      got_data.delete();
      got_err.delete();
      got_addr.delete();
      got_cycle.delete();
   endtask

   task automatic add_random(input int count);
      logic [31:0] r;
      data_t       d;
      lsu_size_e   sz;
      logic [1:0]  lane;
      offset_t     off;
      addr_t       a;
      for (int k = 0; k < count; k++) begin
         r  = $random(seed);
         d  = $random(seed);
         sz = (r[5:4] == 2'd0) ? SIZE_BYTE : (r[5:4] == 2'd1) ? SIZE_HALF : SIZE_WORD;
         lane = (sz == SIZE_BYTE) ? r[7:6] : (sz == SIZE_HALF) ? {r[7], 1'b0} : 2'b00;
         a    = DCCM_BASE + 32'h100 + {r[3:0], 2'b00} + lane;
         off  = offset_t'(r[19:8]);
         add_req(r[20], sz, r[21], a - {{20{off[11]}}, off}, off, d, ERR_NONE);
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == test_base) begin
         $display("test %0d %s: ok", tests, name);
      end else begin
         $display("test %0d %s: %0d errors", tests, name, errors - test_base);
      end
      test_base = errors;
   endtask

   // ************************************************************
   // Test sequence
   // ************************************************************

   initial begin
      seed         = 4;
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req_store    = 1'b0;
      req_unsigned = 1'b0;
      req_size     = SIZE_WORD;
      rs1          = '0;
      store_data   = '0;
      offset       = '0;
      saw_stall    = 1'b0;
      timed_out    = 1'b0;
      test_base    = 0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      // Store then load at once, then again from the DCCM
      add_req(1, SIZE_WORD, 0, DCCM_BASE, 12'sh010, 32'hDEAD_BEEF, ERR_NONE);
      add_req(0, SIZE_WORD, 0, DCCM_BASE, 12'sh010, 32'h0, ERR_NONE);
      add_req(0, SIZE_WORD, 0, DCCM_BASE + 32'h20, -12'sd16, 32'h0, ERR_NONE);
      run_table();
      add_req(0, SIZE_WORD, 0, DCCM_BASE, 12'sh010, 32'h0, ERR_NONE);
      add_req(0, SIZE_HALF, 1, DCCM_BASE, 12'sh012, 32'h0, ERR_NONE);
      run_table();
      end_test("store to load forwarding");

      add_req(1, SIZE_WORD, 0, DCCM_BASE, 12'sh020, 32'h80F1_C3A5, ERR_NONE);
      add_req(0, SIZE_BYTE, 0, DCCM_BASE, 12'sh020, 32'h0, ERR_NONE);
      add_req(0, SIZE_BYTE, 1, DCCM_BASE, 12'sh020, 32'h0, ERR_NONE);
      add_req(0, SIZE_BYTE, 0, DCCM_BASE, 12'sh021, 32'h0, ERR_NONE);
      add_req(0, SIZE_BYTE, 1, DCCM_BASE, 12'sh021, 32'h0, ERR_NONE);
      add_req(0, SIZE_HALF, 0, DCCM_BASE, 12'sh022, 32'h0, ERR_NONE);
      add_req(0, SIZE_HALF, 1, DCCM_BASE, 12'sh022, 32'h0, ERR_NONE);
      add_req(0, SIZE_HALF, 0, DCCM_BASE, 12'sh020, 32'h0, ERR_NONE);
      add_req(1, SIZE_BYTE, 0, DCCM_BASE, 12'sh023, 32'h0000_009A, ERR_NONE);
      add_req(0, SIZE_BYTE, 0, DCCM_BASE, 12'sh023, 32'h0, ERR_NONE);
      add_req(0, SIZE_BYTE, 1, DCCM_BASE, 12'sh023, 32'h0, ERR_NONE);
      add_req(0, SIZE_WORD, 0, DCCM_BASE, 12'sh020, 32'h0, ERR_NONE);
      run_table();
      end_test("sign and zero extension");

      add_req(0, SIZE_HALF, 0, DCCM_BASE, 12'sh021, 32'h0, ERR_MISALIGN);
      add_req(0, SIZE_WORD, 0, DCCM_BASE, 12'sh022, 32'h0, ERR_MISALIGN);
      add_req(1, SIZE_WORD, 0, DCCM_BASE, 12'sh012, 32'h1111_1111, ERR_MISALIGN);
      add_req(1, SIZE_HALF, 0, DCCM_BASE, 12'sh013, 32'h2222_2222, ERR_MISALIGN);
      add_req(0, SIZE_WORD, 0, DCCM_BASE, 12'sh010, 32'h0, ERR_NONE);
      add_req(0, SIZE_WORD, 0, DCCM_BASE, 12'sh020, 32'h0, ERR_NONE);
      run_table();
      end_test("misaligned accesses");

      // Faulting stores would alias onto word 0 if they got through
      add_req(1, SIZE_WORD, 0, DCCM_BASE, 12'sh000, 32'h0123_4567, ERR_NONE);
      add_req(1, SIZE_WORD, 0, DCCM_BASE + 32'h1000, 12'sh000, 32'h5555_5555, ERR_ACCESS);
      add_req(0, SIZE_WORD, 0, DCCM_BASE, -12'sd4, 32'h0, ERR_ACCESS);
      add_req(1, SIZE_WORD, 0, DCCM_BASE + 32'hFFC, 12'sh004, 32'h6666_6666, ERR_ACCESS);
      add_req(0, SIZE_WORD, 0, DCCM_BASE, -12'sd2, 32'h0, ERR_MISALIGN);
      add_req(0, SIZE_BYTE, 0, DCCM_BASE + 32'hFFF, 12'sh001, 32'h0, ERR_ACCESS);
      run_table();
      add_req(0, SIZE_WORD, 0, DCCM_BASE, 12'sh000, 32'h0, ERR_NONE);
      run_table();
      end_test("window access faults");

      saw_stall = 1'b0;
      for (int k = 0; k < 2 * STBUF_DEPTH; k++) begin
         add_req(1, SIZE_WORD, 0, DCCM_BASE + 32'h40, offset_t'(4 * k),
                 32'hA000_0000 | (k * 32'h1111), ERR_NONE);
      end
      for (int k = 0; k < 2 * STBUF_DEPTH; k++) begin
         add_req(0, SIZE_WORD, 0, DCCM_BASE + 32'h40, offset_t'(4 * k), 32'h0, ERR_NONE);
      end
      run_table();
      if (!saw_stall && !timed_out) begin
         errors++;
         $display("Stall never rose during the store burst");
      end
      end_test("store burst and stall");

      for (int k = 0; k < 16; k++) begin
         add_req(1, SIZE_WORD, 0, DCCM_BASE + 32'h100, offset_t'(4 * k), $random(seed),
                 ERR_NONE);
      end
      add_random(48);
      run_table();
      end_test("random mix");

      tests++;
      if (lat_errors == 0) begin
         $display("test %0d fixed two cycle latency: ok", tests);
      end else begin
         $display("test %0d fixed two cycle latency: %0d errors", tests, lat_errors);
      end

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
lsu_pkg.sv
lsu_dccm.sv
lsu_addr_check.sv
lsu_stbuf.sv
lsu_load_align.sv
lsu_pipe_ctl.sv
lsu_top.sv
tb_clk_gen.sv
tb_lsu.sv
